// ==== Makefile ====
TOP = tb_vw_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f versat_write.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== rtl/vw_bus_pkg.sv ====
package vw_bus_pkg;

   // datapath width and bytes per word
   localparam int DATA_W = 32;
   localparam int BYTES_W = DATA_W / 8;

   // one databus beat, payload only
   typedef struct packed {
      logic [vw_cfg_pkg::AXI_ADDR_W-1:0] addr;
      logic [vw_cfg_pkg::LEN_W-1:0]      len;
      logic [DATA_W-1:0]                 wdata;
      logic                              last;
   } db_beat_t;

   // store address generator
   typedef enum logic [1:0] {
      AG_IDLE,
      AG_DELAY,
      AG_RUN
   } agen_state_t;

   // burst reader
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_BURST,
      RD_DONE
   } rd_state_t;

   // databus arbiter
   typedef enum logic {
      ARB_IDLE,
      ARB_LOCKED
   } arb_state_t;

endpackage

// ==== rtl/vw_cfg_pkg.sv ====
package vw_cfg_pkg;

   // local buffer address, top bit picks the ping-pong half
   localparam int ADDR_W = 6;

   // inner period counter
   localparam int PERIOD_W = 4;

   // start delay before the first store
   localparam int DELAY_W = 4;

   // external databus address and burst length in bytes
   localparam int AXI_ADDR_W = 32;
   localparam int LEN_W = 16;

   // configuration of one lane
   typedef struct packed {
      // burst on or off
      logic                  enabled;
      logic                  ping_pong;
      logic [AXI_ADDR_W-1:0] ext_addr;
      // beats in the burst, minus one
      logic [ADDR_W-1:0]     count_minus_one;
      // two-level store addressing
      logic [ADDR_W-1:0]     start;
      logic [ADDR_W-1:0]     incr;
      logic [PERIOD_W-1:0]   per;
      logic [ADDR_W-1:0]     shift;
      logic [ADDR_W-1:0]     iter;
      logic [DELAY_W-1:0]    delay;
   } lane_cfg_t;

endpackage

// ==== rtl/vw_databus_arb.sv ====
module vw_databus_arb #(
   parameter int NUM_LANES = 2
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic [NUM_LANES-1:0]                   lane_valid_i,
   input  vw_bus_pkg::db_beat_t [NUM_LANES-1:0]   lane_beat_i,
   output logic [NUM_LANES-1:0]                   lane_ready_o,
   output logic                                   databus_valid_o,
   output vw_bus_pkg::db_beat_t                   databus_o,
   input  logic                                   databus_ready_i
);

   localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   vw_bus_pkg::arb_state_t   state_q;
   logic [SEL_W-1:0]         sel_q;
   logic [SEL_W-1:0]         rr_q;
   logic [SEL_W-1:0]         pick;
   logic                     any_req;
   logic                     locked;

   // first requester at or after the round-robin pointer
   always_comb begin
      int idx;
      pick = rr_q;
      any_req = 1'b0;
      for (int i = 0; i < NUM_LANES; i++) begin
         idx = int'(rr_q) + i;
         if (idx >= NUM_LANES) begin
            idx = idx - NUM_LANES;
         end
         if (!any_req && lane_valid_i[idx]) begin
            any_req = 1'b1;
            pick = SEL_W'(idx);
         end
      end
   end

   assign locked = (state_q == vw_bus_pkg::ARB_LOCKED);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= vw_bus_pkg::ARB_IDLE;
         sel_q <= '0;
         rr_q <= '0;
      end else if (!locked) begin
         if (any_req) begin
            sel_q <= pick;
            state_q <= vw_bus_pkg::ARB_LOCKED;
         end
      end else if (databus_valid_o && databus_ready_i && databus_o.last) begin
         // burst over, the next lane gets priority
         state_q <= vw_bus_pkg::ARB_IDLE;
         rr_q <= (int'(sel_q) == NUM_LANES - 1) ? '0 : sel_q + 1'b1;
      end
   end

   assign databus_valid_o = locked && lane_valid_i[sel_q];
   assign databus_o = lane_beat_i[sel_q];

   always_comb begin
      lane_ready_o = '0;
      lane_ready_o[sel_q] = locked && databus_ready_i;
   end

endmodule

// ==== rtl/vw_run_ctrl.sv ====
module vw_run_ctrl #(
   parameter int NUM_LANES = 2,
   localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   cfg_we_i,
   input  logic [LANE_W-1:0]                      cfg_lane_i,
   input  vw_cfg_pkg::lane_cfg_t                  cfg_i,
   input  logic                                   run_i,
   input  logic [NUM_LANES-1:0]                   lane_done_i,
   output logic [NUM_LANES-1:0]                   lane_run_o,
   output vw_cfg_pkg::lane_cfg_t [NUM_LANES-1:0]  lane_cfg_o,
   output logic                                   done_o
);

   vw_cfg_pkg::lane_cfg_t [NUM_LANES-1:0]  cfg_q;
   logic                                   done_q;
   logic                                   run_acc;

   // lane configuration registers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg_q <= '0;
      end else if (cfg_we_i) begin
         for (int l = 0; l < NUM_LANES; l++) begin
            if (cfg_lane_i == LANE_W'(l)) begin
               cfg_q[l] <= cfg_i;
            end
         end
      end
   end

   // a run only starts when everything is idle
   assign run_acc = run_i && done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q <= 1'b1;
      end else if (run_acc) begin
         done_q <= 1'b0;
      end else if (!done_q && (&lane_done_i)) begin
         done_q <= 1'b1;
      end
   end

   assign lane_run_o = {NUM_LANES{run_acc}};
   assign lane_cfg_o = cfg_q;
   assign done_o = done_q;

endmodule

// ==== rtl/vw_store_addrgen.sv ====
module vw_store_addrgen (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            run_i,
   input  vw_cfg_pkg::lane_cfg_t           cfg_i,
   output logic                            valid_o,
   output logic [vw_cfg_pkg::ADDR_W-1:0]   addr_o,
   output logic                            done_o
);

   vw_bus_pkg::agen_state_t           state_q;
   logic [vw_cfg_pkg::DELAY_W-1:0]    dcnt_q;
   logic [vw_cfg_pkg::PERIOD_W-1:0]   icnt_q;
   logic [vw_cfg_pkg::ADDR_W-1:0]     jcnt_q;
   logic [vw_cfg_pkg::ADDR_W-1:0]     acc_q;
   logic [vw_cfg_pkg::ADDR_W-1:0]     row_q;
   logic                              start_run;
   logic                              inner_end;
   logic                              outer_end;

   assign start_run = (state_q == vw_bus_pkg::AG_IDLE) && run_i;
   assign inner_end = (icnt_q == cfg_i.per);
   assign outer_end = (jcnt_q == cfg_i.iter);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= vw_bus_pkg::AG_IDLE;
         dcnt_q <= '0;
         icnt_q <= '0;
         jcnt_q <= '0;
      end else begin
         case (state_q)
            vw_bus_pkg::AG_IDLE: begin
               if (run_i) begin
                  dcnt_q <= cfg_i.delay;
                  icnt_q <= '0;
                  jcnt_q <= '0;
                  // zero delay stores in the very next cycle
                  state_q <= (cfg_i.delay == '0) ? vw_bus_pkg::AG_RUN : vw_bus_pkg::AG_DELAY;
               end
            end
            vw_bus_pkg::AG_DELAY: begin
               dcnt_q <= dcnt_q - 1'b1;
               if (dcnt_q == vw_cfg_pkg::DELAY_W'(1)) begin
                  state_q <= vw_bus_pkg::AG_RUN;
               end
            end
            vw_bus_pkg::AG_RUN: begin
               if (inner_end) begin
                  icnt_q <= '0;
                  if (outer_end) begin
                     state_q <= vw_bus_pkg::AG_IDLE;
                  end else begin
                     jcnt_q <= jcnt_q + 1'b1;
                  end
               end else begin
                  icnt_q <= icnt_q + 1'b1;
               end
            end
            default: state_q <= vw_bus_pkg::AG_IDLE;
         endcase
      end
   end

   // row base steps by shift, address steps by incr inside a row
   always_ff @(posedge clk) begin
      if (start_run) begin
         acc_q <= cfg_i.start;
         row_q <= cfg_i.start;
      end else if (state_q == vw_bus_pkg::AG_RUN) begin
         if (inner_end) begin
            acc_q <= row_q + cfg_i.shift;
            row_q <= row_q + cfg_i.shift;
         end else begin
            acc_q <= acc_q + cfg_i.incr;
         end
      end
   end

   assign valid_o = (state_q == vw_bus_pkg::AG_RUN);
   assign addr_o = acc_q;
   assign done_o = (state_q == vw_bus_pkg::AG_IDLE);

endmodule

// ==== rtl/vw_top.sv ====
module vw_top #(
   parameter int NUM_LANES = 2,
   parameter int BUF_ADDR_W = 6,
   localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
   input  logic                                      clk,
   input  logic                                      rst,
   input  logic                                      cfg_we_i,
   input  logic [LANE_W-1:0]                         cfg_lane_i,
   input  vw_cfg_pkg::lane_cfg_t                     cfg_i,
   input  logic                                      run_i,
   output logic                                      done_o,
   input  logic [NUM_LANES*vw_bus_pkg::DATA_W-1:0]   in_data_i,
   output logic                                      databus_valid_o,
   output vw_bus_pkg::db_beat_t                      databus_o,
   input  logic                                      databus_ready_i
);

   logic [NUM_LANES-1:0]                   lane_run;
   vw_cfg_pkg::lane_cfg_t [NUM_LANES-1:0]  lane_cfg;
   logic [NUM_LANES-1:0]                   lane_done;
   logic [NUM_LANES-1:0]                   lane_valid;
   logic [NUM_LANES-1:0]                   lane_ready;
   vw_bus_pkg::db_beat_t [NUM_LANES-1:0]   lane_beat;

   vw_run_ctrl #(.NUM_LANES(NUM_LANES)) u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .cfg_we_i    (cfg_we_i),
      .cfg_lane_i  (cfg_lane_i),
      .cfg_i       (cfg_i),
      .run_i       (run_i),
      .lane_done_i (lane_done),
      .lane_run_o  (lane_run),
      .lane_cfg_o  (lane_cfg),
      .done_o      (done_o)
   );

   for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
      vw_write_unit #(.BUF_ADDR_W(BUF_ADDR_W)) u_lane (
         .clk       (clk),
         .rst       (rst),
         .run_i     (lane_run[l]),
         .cfg_i     (lane_cfg[l]),
         .in_data_i (in_data_i[l*vw_bus_pkg::DATA_W +: vw_bus_pkg::DATA_W]),
         .valid_o   (lane_valid[l]),
         .beat_o    (lane_beat[l]),
         .ready_i   (lane_ready[l]),
         .done_o    (lane_done[l])
      );
   end

   vw_databus_arb #(.NUM_LANES(NUM_LANES)) u_arb (
      .clk             (clk),
      .rst             (rst),
      .lane_valid_i    (lane_valid),
      .lane_beat_i     (lane_beat),
      .lane_ready_o    (lane_ready),
      .databus_valid_o (databus_valid_o),
      .databus_o       (databus_o),
      .databus_ready_i (databus_ready_i)
   );

endmodule

// ==== rtl/vw_write_unit.sv ====
module vw_write_unit #(
   parameter int BUF_ADDR_W = 6
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run_i,
   input  vw_cfg_pkg::lane_cfg_t             cfg_i,
   input  logic [vw_bus_pkg::DATA_W-1:0]     in_data_i,
   output logic                              valid_o,
   output vw_bus_pkg::db_beat_t              beat_o,
   input  logic                              ready_i,
   output logic                              done_o
);

   localparam int DEPTH = 2 ** BUF_ADDR_W;

   logic                              pp_q;
   logic                              st_half;
   logic                              rd_half;
   logic                              gen_valid;
   logic [vw_cfg_pkg::ADDR_W-1:0]     gen_addr;
   logic                              gen_done;
   logic [BUF_ADDR_W-1:0]             st_addr;
   logic [BUF_ADDR_W-1:0]             rd_addr;
   logic [vw_bus_pkg::DATA_W-1:0]     mem [DEPTH];

   vw_bus_pkg::rd_state_t             rd_state_q;
   logic [vw_cfg_pkg::ADDR_W:0]       rd_ptr_q;
   logic [vw_cfg_pkg::ADDR_W:0]       cnt_max;
   logic                              valid_q;
   logic [vw_bus_pkg::DATA_W-1:0]     data_q;
   logic                              last_q;
   logic                              load;
   logic                              xfer;
   logic [vw_cfg_pkg::LEN_W-1:0]      beat_cnt;

   vw_store_addrgen u_agen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .cfg_i   (cfg_i),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  (gen_done)
   );

   // ping-pong state flips on every run in ping-pong mode
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_q <= 1'b0;
      end else if (run_i) begin
         pp_q <= cfg_i.ping_pong ? ~pp_q : 1'b0;
      end
   end

   // stores go to one half, the burst reads the other
   assign st_half = cfg_i.ping_pong & pp_q;
   assign rd_half = cfg_i.ping_pong & ~pp_q;

   assign st_addr = {st_half, gen_addr[BUF_ADDR_W-2:0]};
   assign rd_addr = {rd_half, rd_ptr_q[BUF_ADDR_W-2:0]};

   always_ff @(posedge clk) begin
      if (gen_valid) begin
         mem[st_addr] <= in_data_i;
      end
   end

   // burst reader
   assign cnt_max = {1'b0, cfg_i.count_minus_one};
   assign xfer = valid_q && ready_i;
   // refill the hold register when empty or draining this cycle
   assign load = (rd_state_q == vw_bus_pkg::RD_BURST) && (!valid_q || ready_i)
                 && (rd_ptr_q <= cnt_max);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_state_q <= vw_bus_pkg::RD_IDLE;
         rd_ptr_q <= '0;
         valid_q <= 1'b0;
      end else if (run_i) begin
         rd_ptr_q <= '0;
         valid_q <= 1'b0;
         rd_state_q <= cfg_i.enabled ? vw_bus_pkg::RD_BURST : vw_bus_pkg::RD_DONE;
      end else if (rd_state_q == vw_bus_pkg::RD_BURST) begin
         if (load) begin
            valid_q <= 1'b1;
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end else if (xfer) begin
            valid_q <= 1'b0;
         end
         if (xfer && last_q) begin
            rd_state_q <= vw_bus_pkg::RD_DONE;
         end
      end
   end

   // beat payload
   always_ff @(posedge clk) begin
      if (load) begin
         data_q <= mem[rd_addr];
         last_q <= (rd_ptr_q == cnt_max);
      end
   end

   assign beat_cnt = vw_cfg_pkg::LEN_W'(cfg_i.count_minus_one) + 1'b1;

   assign valid_o = valid_q;
   assign beat_o.addr = cfg_i.ext_addr;
   assign beat_o.len = beat_cnt * vw_cfg_pkg::LEN_W'(vw_bus_pkg::BYTES_W);
   assign beat_o.wdata = data_q;
   assign beat_o.last = last_q;

   assign done_o = gen_done && (rd_state_q != vw_bus_pkg::RD_BURST);

endmodule

// ==== test/tb_vw_top.sv ====
module tb_vw_top;

   localparam int NUM_LANES = 2;
   localparam int BUF_ADDR_W = 6;
   localparam int HALF = 2 ** (BUF_ADDR_W - 1);
   localparam int LANE_WORDS = 11;
   localparam int RUN_WORDS = 1 + NUM_LANES * LANE_WORDS;
   // cycles allowed for one run, config to done
   localparam int RUN_BOUND = 600;

   logic                                      clk;
   logic                                      rst;
   logic                                      cfg_we_i;
   logic [0:0]                                cfg_lane_i;
   vw_cfg_pkg::lane_cfg_t                     cfg_i;
   logic                                      run_i;
   logic                                      done_o;
   logic [NUM_LANES*vw_bus_pkg::DATA_W-1:0]   in_data_i;
   logic                                      databus_valid_o;
   vw_bus_pkg::db_beat_t                      databus_o;
   logic                                      databus_ready_i;

   logic [31:0]            tdata [256];
   logic [31:0]            lfsr;
   logic [31:0]            lane_base [NUM_LANES];
   logic [31:0]            model_mem [NUM_LANES][2*HALF];
   logic                   model_pp [NUM_LANES];
   vw_bus_pkg::db_beat_t   exp_q [NUM_LANES][$];
   int                     num_runs;
   int                     run_cyc;
   int                     errors;
   int                     beats_seen;
   int                     cur_lane;

   vw_top #(.NUM_LANES(NUM_LANES), .BUF_ADDR_W(BUF_ADDR_W)) dut0 (
      .clk             (clk),
      .rst             (rst),
      .cfg_we_i        (cfg_we_i),
      .cfg_lane_i      (cfg_lane_i),
      .cfg_i           (cfg_i),
      .run_i           (run_i),
      .done_o          (done_o),
      .in_data_i       (in_data_i),
      .databus_valid_o (databus_valid_o),
      .databus_o       (databus_o),
      .databus_ready_i (databus_ready_i)
   );

   always #2 clk = ~clk;

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         errors++;
         $display("ERROR at time %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic drive_stream();
      for (int l = 0; l < NUM_LANES; l++) begin
         in_data_i[l*vw_bus_pkg::DATA_W +: vw_bus_pkg::DATA_W] = lane_base[l] + 32'(run_cyc);
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1;
      run_i = 1'b0;
      cfg_we_i = 1'b0;
      lfsr = lfsr_step(lfsr);
      databus_ready_i = lfsr[0];
      run_cyc++;
      drive_stream();
   endtask

   task automatic predict_lane(input int l, input vw_cfg_pkg::lane_cfg_t c);
      vw_bus_pkg::db_beat_t e;
      int st_half;
      int rd_half;
      int a;
      int k;
      model_pp[l] = c.ping_pong ? ~model_pp[l] : 1'b0;
      st_half = (c.ping_pong && model_pp[l]) ? HALF : 0;
      rd_half = (c.ping_pong && !model_pp[l]) ? HALF : 0;
      // burst sees the buffer as it was before this run's stores
      if (c.enabled) begin
         for (int b = 0; b <= int'(c.count_minus_one); b++) begin
            e.addr = c.ext_addr;
            e.len = 16'((int'(c.count_minus_one) + 1) * vw_bus_pkg::BYTES_W);
            e.wdata = model_mem[l][rd_half + b % HALF];
            e.last = (b == int'(c.count_minus_one));
            exp_q[l].push_back(e);
         end
      end
      k = 0;
      for (int j = 0; j <= int'(c.iter); j++) begin
         for (int i = 0; i <= int'(c.per); i++) begin
            a = (int'(c.start) + i * int'(c.incr) + j * int'(c.shift)) % HALF;
            // store k takes the word of cycle 1 + delay + k after the run pulse
            model_mem[l][st_half + a] = lane_base[l] + 32'(1 + int'(c.delay) + k);
            k++;
         end
      end
   endtask

   task automatic check_beat(input vw_bus_pkg::db_beat_t b);
      vw_bus_pkg::db_beat_t e;
      beats_seen++;
      if (cur_lane < 0) begin
         for (int l = NUM_LANES - 1; l >= 0; l--) begin
            if (exp_q[l].size() > 0 && exp_q[l][0].addr == b.addr) begin
               cur_lane = l;
            end
         end
      end
      if (cur_lane < 0 || exp_q[cur_lane].size() == 0) begin
         errors++;
         $display("unexpected databus beat at time %0t to address %h", $time, b.addr);
      end else begin
         e = exp_q[cur_lane].pop_front();
         compare("databus_o.addr", e.addr, b.addr);
         compare("databus_o.len", e.len, b.len);
         compare("databus_o.wdata", e.wdata, b.wdata);
         compare("databus_o.last", e.last, b.last);
         if (e.last) begin
            cur_lane = -1;
         end
      end
   endtask

   task automatic do_run(input int r);
      vw_cfg_pkg::lane_cfg_t c;
      int w;
      int p;
      w = 1 + r * RUN_WORDS;
      for (int l = 0; l < NUM_LANES; l++) begin
         p = w + 1 + l * LANE_WORDS;
         c.enabled = tdata[p][0];
         c.ping_pong = tdata[p+1][0];
         c.ext_addr = tdata[p+2];
         c.count_minus_one = tdata[p+3][vw_cfg_pkg::ADDR_W-1:0];
         c.start = tdata[p+4][vw_cfg_pkg::ADDR_W-1:0];
         c.incr = tdata[p+5][vw_cfg_pkg::ADDR_W-1:0];
         c.per = tdata[p+6][vw_cfg_pkg::PERIOD_W-1:0];
         c.shift = tdata[p+7][vw_cfg_pkg::ADDR_W-1:0];
         c.iter = tdata[p+8][vw_cfg_pkg::ADDR_W-1:0];
         c.delay = tdata[p+9][vw_cfg_pkg::DELAY_W-1:0];
         lane_base[l] = tdata[p+10];
         step_cycle();
         cfg_we_i = 1'b1;
         cfg_lane_i = 1'(l);
         cfg_i = c;
         predict_lane(l, c);
      end
      step_cycle();
      run_cyc = 0;
      drive_stream();
      run_i = 1'b1;
      step_cycle();
      compare("done_o", 1'b0, done_o);
      // second request while busy
      if (tdata[w][0]) begin
         run_i = 1'b1;
      end
      while (!done_o) begin
         step_cycle();
      end
      for (int l = 0; l < NUM_LANES; l++) begin
         compare("pending beats at done_o", 0, exp_q[l].size());
      end
   endtask

   always @(negedge clk) begin
      if (!rst && databus_valid_o && databus_ready_i) begin
         check_beat(databus_o);
      end
   end

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      cfg_we_i = 1'b0;
      cfg_lane_i = '0;
      cfg_i = '0;
      run_i = 1'b0;
      in_data_i = '0;
      databus_ready_i = 1'b0;
      lfsr = 32'h5107_ddd1;
      errors = 0;
      beats_seen = 0;
      cur_lane = -1;
      run_cyc = 0;
      for (int l = 0; l < NUM_LANES; l++) begin
         lane_base[l] = '0;
         model_pp[l] = 1'b0;
      end
      $readmemh("test/vw_testdata.txt", tdata);
      num_runs = int'(tdata[0]);
      repeat (3) step_cycle();
      rst = 1'b0;
      @(negedge clk);
      compare("done_o", 1'b1, done_o);
      compare("databus_valid_o", 1'b0, databus_valid_o);
      // idle cycles under random ready before the first configuration
      repeat (8) step_cycle();
      compare("beats after reset", 0, beats_seen);
      for (int r = 0; r < num_runs; r++) begin
         do_run(r);
      end
      // stray bursts would show up here
      repeat (20) step_cycle();
      $display("errors: %0d, assertion failures: %0d", errors, dut0.props0.fail_cnt);
      if (errors == 0 && dut0.props0.fail_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #1;
      #(4 * (40 + num_runs * RUN_BOUND));
      $display("timeout: %0d runs did not complete in time", num_runs);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== test/vw_testdata.txt ====
// first word: run count; run line: 1 to request a second run while busy, else 0
// lane line: enabled ping_pong ext_addr count_minus_one start incr per shift iter delay base
6
0
0 0 10000000 00 04 04 7 01 03 5 a0000000
0 0 20000000 00 00 01 f 10 01 0 b0000000
1
1 0 10000000 1b 1c 01 3 00 00 0 a1000000
1 0 20000000 0f 10 02 7 01 01 3 b1000000
0
1 1 10000040 1f 00 01 f 10 01 1 a2000000
1 1 20000100 07 00 01 7 08 00 0 b2000000
0
1 1 10000080 1f 05 03 a 00 00 2 a3000000
1 1 20000200 07 00 01 7 00 01 4 b3000000
1
1 1 100000c0 0f 00 01 3 04 00 0 a4000000
1 1 20000300 07 00 01 3 04 01 0 b4000000
0
0 0 10000100 00 00 01 1 00 00 0 a5000000
1 0 20000400 03 0a 01 3 00 00 0 b5000000

// ==== test/vw_top_props.sv ====
module vw_top_props #(
   parameter int NUM_LANES = 2
) (
   input logic                   clk,
   input logic                   rst,
   input logic                   run_i,
   input logic                   done_o,
   input logic                   databus_valid_o,
   input vw_bus_pkg::db_beat_t   databus_o,
   input logic                   databus_ready_i
);

   int fail_cnt = 0;

   // a stalled beat keeps valid and payload
   a_hold: assert property (@(posedge clk) disable iff (rst)
      databus_valid_o && !databus_ready_i |=> databus_valid_o && $stable(databus_o))
   else begin
      fail_cnt++;
      $error("databus beat changed while the slave stalled");
   end

   // idle engine keeps the bus quiet
   a_idle: assert property (@(posedge clk) disable iff (rst)
      done_o && !databus_valid_o || !done_o)
   else begin
      fail_cnt++;
      $error("databus valid while done is high");
   end

   // an accepted run keeps done low until the lanes have started
   a_start: assert property (@(posedge clk) disable iff (rst)
      done_o && run_i |=> !done_o ##1 !done_o)
   else begin
      fail_cnt++;
      $error("done did not stay low after an accepted run");
   end

   // done rises only once the last beat has left the bus
   a_finish: assert property (@(posedge clk) disable iff (rst)
      !done_o && databus_valid_o |=> !done_o)
   else begin
      fail_cnt++;
      $error("done rose while a beat was still on the databus");
   end

endmodule

bind vw_top vw_top_props #(.NUM_LANES(NUM_LANES)) props0 (
   .clk             (clk),
   .rst             (rst),
   .run_i           (run_i),
   .done_o          (done_o),
   .databus_valid_o (databus_valid_o),
   .databus_o       (databus_o),
   .databus_ready_i (databus_ready_i)
);

// ==== versat_write.f ====
rtl/vw_cfg_pkg.sv
rtl/vw_bus_pkg.sv
rtl/vw_store_addrgen.sv
rtl/vw_write_unit.sv
rtl/vw_run_ctrl.sv
rtl/vw_databus_arb.sv
rtl/vw_top.sv
test/vw_top_props.sv
test/tb_vw_top.sv
